// ==== hw/game_pkg.sv ====
`default_nettype none

package game_pkg;

   // ------------------------------------------------------------
   // Move and sequence sizes
   // ------------------------------------------------------------

   // One bit per LED and per button
   localparam int move_width = 4;

   // Moves in a complete game
   localparam int seq_len = 16;

   typedef logic [move_width-1:0] move_t;

   // Move index, round number and memory address
   typedef logic [$clog2(seq_len)-1:0] index_t;

   // Preset first entry, lowest LED only
   localparam move_t first_move = move_t'(1);

   // ------------------------------------------------------------
   // Controller states
   // ------------------------------------------------------------

   typedef enum logic [3:0] {
      idle,
      init,
      show,
      round_start,
      wait_move,
      check_move,
      next_move,
      last_move,
      wait_new,
      store_new,
      next_round,
      won,
      lost_error,
      lost_timeout
   } state_t;

endpackage

`default_nettype wire

// ==== hw/phase_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module phase_timer #(
   parameter int limit = 2000
) (
   input  wire  clock,
   input  wire  reset,
   input  wire  clear,
   input  wire  run,
   output logic done
);

   localparam int width = $clog2(limit + 1);

   logic [width-1:0] count;

   // Counts while running, then parks at the limit
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         count <= '0;
      end else if (clear) begin
         count <= '0;
      end else if (run && (count != width'(limit))) begin
         count <= count + 1'b1;
      end
   end

   assign done = run && (count == width'(limit));

endmodule

`default_nettype wire

// ==== hw/sequence_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module sequence_memory (
   input  wire                   clock,
   input  wire                   reset,
   input  wire                   write_new,
   input  wire game_pkg::index_t address,
   input  wire game_pkg::move_t  data,
   output game_pkg::move_t       expected
);

   game_pkg::move_t  mem [game_pkg::seq_len];
   game_pkg::index_t read_address;

   // Entry 0 preset, later entries filled one per round
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < game_pkg::seq_len; i++) begin
            mem[i] <= (i == 0) ? game_pkg::first_move : '0;
         end
      end else if (write_new) begin
         mem[address] <= data;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         read_address <= '0;
      end else begin
         read_address <= address;
      end
   end

   // Data one cycle behind the address
   assign expected = mem[read_address];

endmodule

`default_nettype wire

// ==== hw/round_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module round_tracker (
   input  wire               clock,
   input  wire               reset,
   input  wire               clear_move,
   input  wire               count_move,
   input  wire               clear_round,
   input  wire               count_round,
   output game_pkg::index_t  move_index,
   output logic              end_of_round,
   output logic              end_of_game
);

   game_pkg::index_t round;

   // ------------------------------------------------------------
   // Counters
   // ------------------------------------------------------------

   // Position inside the current round, also the memory address
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         move_index <= '0;
      end else if (clear_move) begin
         move_index <= '0;
      end else if (count_move) begin
         move_index <= move_index + 1'b1;
      end
   end

   // Index of the last move to repeat this round
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         round <= '0;
      end else if (clear_round) begin
         round <= '0;
      end else if (count_round) begin
         round <= round + 1'b1;
      end
   end

   // ------------------------------------------------------------
   // Flags
   // ------------------------------------------------------------

   assign end_of_round = (move_index == round);

   // Final round repeats the whole sequence
   assign end_of_game  = (round == game_pkg::index_t'(game_pkg::seq_len - 1));

endmodule

`default_nettype wire

// ==== hw/player_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module player_port (
   input  wire                  clock,
   input  wire                  reset,
   input  wire game_pkg::move_t buttons,
   input  wire                  move_req,
   input  wire                  accept,
   input  wire                  clear_move_reg,
   input  wire                  show,
   input  wire game_pkg::move_t expected,
   output logic                 move_ack,
   output logic                 captured,
   output logic                 match,
   output game_pkg::move_t      move,
   output game_pkg::move_t      leds
);

   // ------------------------------------------------------------
   // Four-phase handshake
   // ------------------------------------------------------------

   // New request, not yet acknowledged, controller ready
   assign captured = move_req && !move_ack && accept;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         move_ack <= 1'b0;
      end else if (captured) begin
         move_ack <= 1'b1;
      end else if (move_ack && !move_req) begin
         move_ack <= 1'b0;
      end
   end

   // Latched move, buttons are stable while req is up
   always_ff @(posedge clock) begin
      if (clear_move_reg) begin
         move <= '0;
      end else if (captured) begin
         move <= buttons;
      end
   end

   // ------------------------------------------------------------
   // Compare and display
   // ------------------------------------------------------------

   assign match = (move == expected);

   // Stored move shown during the show phase, buttons otherwise
   assign leds = show ? expected : buttons;

   // Pending request keeps req and buttons steady until taken
   assert property (@(posedge clock) disable iff (reset)
      $past(move_req && !move_ack && !accept) |-> move_req && $stable(buttons));

endmodule

`default_nettype wire

// ==== hw/game_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_control (
   input  wire  clock,
   input  wire  reset,
   input  wire  start,
   input  wire  captured,
   input  wire  match,
   input  wire  end_of_round,
   input  wire  end_of_game,
   input  wire  timeout,
   input  wire  show_done,
   output logic accept,
   output logic clear_move_reg,
   output logic clear_move,
   output logic count_move,
   output logic clear_round,
   output logic count_round,
   output logic write_new,
   output logic clear_timeout,
   output logic run_timeout,
   output logic clear_show,
   output logic show,
   output logic won,
   output logic lost,
   output logic done
);

   game_pkg::state_t state;
   game_pkg::state_t state_next;

   // ------------------------------------------------------------
   // State register
   // ------------------------------------------------------------

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state <= game_pkg::idle;
      end else begin
         state <= state_next;
      end
   end

   // ------------------------------------------------------------
   // Next state
   // ------------------------------------------------------------

   always_comb begin
      state_next = state;
      case (state)
         game_pkg::idle: begin
            if (start) state_next = game_pkg::init;
         end
         game_pkg::init: begin
            state_next = game_pkg::show;
         end
         game_pkg::show: begin
            if (show_done) state_next = game_pkg::round_start;
         end
         game_pkg::round_start: begin
            state_next = game_pkg::wait_move;
         end
         // Timeout wins over a move arriving in the same cycle
         game_pkg::wait_move: begin
            if (timeout) begin
               state_next = game_pkg::lost_timeout;
            end else if (captured) begin
               state_next = game_pkg::check_move;
            end
         end
         game_pkg::check_move: begin
            if (!match) begin
               state_next = game_pkg::lost_error;
            end else if (end_of_round) begin
               state_next = game_pkg::last_move;
            end else begin
               state_next = game_pkg::next_move;
            end
         end
         game_pkg::next_move: begin
            state_next = game_pkg::wait_move;
         end
         game_pkg::last_move: begin
            if (end_of_game) begin
               state_next = game_pkg::won;
            end else begin
               state_next = game_pkg::wait_new;
            end
         end
         game_pkg::wait_new: begin
            if (timeout) begin
               state_next = game_pkg::lost_timeout;
            end else if (captured) begin
               state_next = game_pkg::store_new;
            end
         end
         game_pkg::store_new: begin
            state_next = game_pkg::next_round;
         end
         game_pkg::next_round: begin
            state_next = game_pkg::round_start;
         end
         game_pkg::won, game_pkg::lost_error, game_pkg::lost_timeout: begin
            if (start) state_next = game_pkg::init;
         end
         default: begin
            state_next = game_pkg::idle;
         end
      endcase
   end

   // ------------------------------------------------------------
   // Moore outputs
   // ------------------------------------------------------------

   // End states park the index at entry 0 so the next show starts there
   assign clear_move     = (state == game_pkg::idle) || (state == game_pkg::init) ||
                           (state == game_pkg::round_start) || done;
   assign count_move     = (state == game_pkg::next_move) || (state == game_pkg::store_new);
   assign clear_round    = (state == game_pkg::idle) || (state == game_pkg::init);
   assign count_round    = (state == game_pkg::next_round);
   assign clear_move_reg = (state == game_pkg::idle) || (state == game_pkg::init);

   // New move goes in at the index already advanced by store_new
   assign write_new      = (state == game_pkg::next_round);

   // Player input only taken while waiting
   assign accept         = (state == game_pkg::wait_move) || (state == game_pkg::wait_new);
   assign run_timeout    = accept;
   assign clear_timeout  = !accept;

   assign clear_show     = (state == game_pkg::idle) || (state == game_pkg::init);
   assign show           = (state == game_pkg::show);

   // Results held until the next start
   assign won            = (state == game_pkg::won);
   assign lost           = (state == game_pkg::lost_error) ||
                           (state == game_pkg::lost_timeout);
   assign done           = won || lost;

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------

   assert property (@(posedge clock) disable iff (reset)
      $past(done && !start) |-> $stable(won) && $stable(lost));

   assert property (@(posedge clock) disable iff (reset)
      write_new |-> $past(state == game_pkg::store_new));

endmodule

`default_nettype wire

// ==== hw/game_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_top #(
   parameter int timeout_cycles = 5000,
   parameter int show_cycles    = 2000
) (
   input  wire                  clock,
   input  wire                  reset,
   input  wire                  start,
   input  wire game_pkg::move_t buttons,
   input  wire                  move_req,
   output logic                 move_ack,
   output game_pkg::move_t      leds,
   output logic                 won,
   output logic                 lost,
   output logic                 done
);

   // Controller to datapath
   logic accept;
   logic clear_move_reg;
   logic clear_move;
   logic count_move;
   logic clear_round;
   logic count_round;
   logic write_new;
   logic clear_timeout;
   logic run_timeout;
   logic clear_show;
   logic show;

   // Datapath to controller
   logic captured;
   logic match;
   logic end_of_round;
   logic end_of_game;
   logic timeout;
   logic show_done;

   game_pkg::index_t move_index;
   game_pkg::move_t  expected;
   game_pkg::move_t  move;

   game_control i_game_control (
      .clock          (clock),
      .reset          (reset),
      .start          (start),
      .captured       (captured),
      .match          (match),
      .end_of_round   (end_of_round),
      .end_of_game    (end_of_game),
      .timeout        (timeout),
      .show_done      (show_done),
      .accept         (accept),
      .clear_move_reg (clear_move_reg),
      .clear_move     (clear_move),
      .count_move     (count_move),
      .clear_round    (clear_round),
      .count_round    (count_round),
      .write_new      (write_new),
      .clear_timeout  (clear_timeout),
      .run_timeout    (run_timeout),
      .clear_show     (clear_show),
      .show           (show),
      .won            (won),
      .lost           (lost),
      .done           (done)
   );

   player_port i_player_port (
      .clock          (clock),
      .reset          (reset),
      .buttons        (buttons),
      .move_req       (move_req),
      .accept         (accept),
      .clear_move_reg (clear_move_reg),
      .show           (show),
      .expected       (expected),
      .move_ack       (move_ack),
      .captured       (captured),
      .match          (match),
      .move           (move),
      .leds           (leds)
   );

   round_tracker i_round_tracker (
      .clock        (clock),
      .reset        (reset),
      .clear_move   (clear_move),
      .count_move   (count_move),
      .clear_round  (clear_round),
      .count_round  (count_round),
      .move_index   (move_index),
      .end_of_round (end_of_round),
      .end_of_game  (end_of_game)
   );

   sequence_memory i_sequence_memory (
      .clock     (clock),
      .reset     (reset),
      .write_new (write_new),
      .address   (move_index),
      .data      (move),
      .expected  (expected)
   );

   // Player inactivity limit
   phase_timer #(
      .limit (timeout_cycles)
   ) timeout_timer (
      .clock (clock),
      .reset (reset),
      .clear (clear_timeout),
      .run   (run_timeout),
      .done  (timeout)
   );

   // Display time of the first move
   phase_timer #(
      .limit (show_cycles)
   ) show_timer (
      .clock (clock),
      .reset (reset),
      .clear (clear_show),
      .run   (show),
      .done  (show_done)
   );

endmodule

`default_nettype wire

// ==== sim/game_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_tb;

   localparam int timeout_cycles = 40;
   localparam int show_cycles    = 8;

   // Longest legal waits for an ack and for a result
   localparam int ack_limit  = timeout_cycles + show_cycles + 20;
   localparam int done_limit = timeout_cycles + 20;

   // A won game is about 151 handshakes of about 5 cycles,
   // five games need roughly 4000 cycles
   localparam int max_cycles = 20000;

   logic            clock;
   logic            reset;
   logic            start;
   game_pkg::move_t buttons;
   logic            move_req;
   logic            move_ack;
   game_pkg::move_t leds;
   logic            won;
   logic            lost;
   logic            done;

   integer seed;
   int     cycle_count = 0;

   // Reference copy of the sequence
   game_pkg::move_t model_seq [game_pkg::seq_len];

   game_top #(
      .timeout_cycles (timeout_cycles),
      .show_cycles    (show_cycles)
   ) i_game_top (
      .clock    (clock),
      .reset    (reset),
      .start    (start),
      .buttons  (buttons),
      .move_req (move_req),
      .move_ack (move_ack),
      .leds     (leds),
      .won      (won),
      .lost     (lost),
      .done     (done)
   );

   always #5 clock = ~clock;

   always @(posedge clock) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("The run reached %0d cycles without finishing", max_cycles);
         stop_run();
      end
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------

   task automatic stop_run();
      $display("Test failures found");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_move(input string name, input game_pkg::move_t expected,
                             input game_pkg::move_t actual);
      if (actual !== expected) begin
         $display("Error: %s expected %h actual %h", name, expected, actual);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Error: %s expected %b actual %b", name, expected, actual);
         stop_run();
      end
   endtask

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed);
      return (r & 32'h7fff_ffff) % n;
   endfunction

   // ------------------------------------------------------------
   // Player model
   // ------------------------------------------------------------

   task automatic wait_ack(input string name);
      int count;
      count = 0;
      @(negedge clock);
      while (move_ack !== 1'b1) begin
         count++;
         if (count > ack_limit) begin
            $display("%s: move_ack never rose after move_req", name);
            stop_run();
         end
         @(negedge clock);
      end
   endtask

   // Full four-phase handshake, first move may be raised during the show
   task automatic enter_move(input string name, input game_pkg::move_t m, input bit in_show);
      if (in_show) begin
         // Display checked against idle buttons before the early request
         repeat (show_cycles / 2) begin
            @(negedge clock);
            check_move({name, " leds in show"}, game_pkg::first_move, leds);
         end
         buttons  = m;
         move_req = 1'b1;
         repeat (show_cycles / 2) begin
            @(negedge clock);
            check_bit({name, " ack held off in show"}, 1'b0, move_ack);
         end
      end else begin
         @(negedge clock);
         buttons  = m;
         move_req = 1'b1;
      end
      wait_ack(name);
      check_move({name, " leds follow buttons"}, m, leds);
      move_req = 1'b0;
      @(negedge clock);
      check_bit({name, " ack drop"}, 1'b0, move_ack);
   endtask

   task automatic start_game(input string name);
      @(negedge clock);
      buttons = '0;
      start   = 1'b1;
      @(negedge clock);
      start = 1'b0;
      // Previous result cleared in init
      check_bit({name, " done after start"}, 1'b0, done);
      check_bit({name, " lost after start"}, 1'b0, lost);
      check_bit({name, " won after start"}, 1'b0, won);
      @(negedge clock);
      check_move({name, " first move shown"}, game_pkg::first_move, leds);
      check_bit({name, " ack in show"}, 1'b0, move_ack);
   endtask

   task automatic wait_done(input string name, output int elapsed);
      elapsed = 0;
      while (done !== 1'b1) begin
         @(negedge clock);
         elapsed++;
         if (elapsed > done_limit) begin
            $display("%s: the game did not end in time", name);
            stop_run();
         end
      end
   endtask

   task automatic check_result(input string name, input game_pkg::state_t predicted);
      check_bit({name, " won"}, predicted == game_pkg::won, won);
      check_bit({name, " lost"}, predicted != game_pkg::won, lost);
      check_bit({name, " done"}, 1'b1, done);
   endtask

   // ------------------------------------------------------------
   // One game against the reference model
   // ------------------------------------------------------------

   task automatic run_game(input string name, input int bad_round, input int bad_index,
                           input int quiet_round, input int quiet_index);
      game_pkg::move_t  m;
      game_pkg::state_t predicted;
      bit               ended;
      int               elapsed;
      predicted    = game_pkg::won;
      ended        = 1'b0;
      model_seq[0] = game_pkg::first_move;
      start_game(name);
      for (int r = 0; r < game_pkg::seq_len && !ended; r++) begin
         for (int i = 0; i <= r && !ended; i++) begin
            if (r == quiet_round && i == quiet_index) begin
               predicted = game_pkg::lost_timeout;
               ended     = 1'b1;
            end else begin
               m = model_seq[game_pkg::index_t'(i)];
               if (r == bad_round && i == bad_index) begin
                  m         = m ^ game_pkg::move_t'(rand_below(15) + 1);
                  predicted = game_pkg::lost_error;
                  ended     = 1'b1;
               end
               enter_move(name, m, r == 0);
            end
         end
         // Append a new move unless the game is over
         if (!ended && r < game_pkg::seq_len - 1) begin
            m = game_pkg::move_t'(rand_below(1 << game_pkg::move_width));
            model_seq[game_pkg::index_t'(r + 1)] = m;
            enter_move(name, m, 1'b0);
         end
      end
      $display("%s: expecting %s", name, predicted.name());
      wait_done(name, elapsed);
      if (predicted == game_pkg::lost_timeout &&
          (elapsed < timeout_cycles || elapsed > timeout_cycles + 8)) begin
         $display("%s: timeout came after %0d idle cycles instead of about %0d",
                  name, elapsed, timeout_cycles);
         stop_run();
      end
      check_result(name, predicted);
      // Result held until the next start
      repeat (3) @(negedge clock);
      check_result({name, " held"}, predicted);
   endtask

   initial begin
      int bad_round;
      int quiet_round;
      clock    = 1'b0;
      reset    = 1'b1;
      start    = 1'b0;
      buttons  = '0;
      move_req = 1'b0;
      seed     = 96;
      repeat (4) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;

      check_bit("reset won", 1'b0, won);
      check_bit("reset lost", 1'b0, lost);
      check_bit("reset done", 1'b0, done);
      check_bit("reset move_ack", 1'b0, move_ack);
      buttons = game_pkg::move_t'(rand_below(16));
      @(negedge clock);
      check_move("idle leds", buttons, leds);

      run_game("won game", -1, -1, -1, -1);

      bad_round = rand_below(game_pkg::seq_len);
      run_game("wrong move game", bad_round, rand_below(bad_round + 1), -1, -1);

      quiet_round = 1 + rand_below(game_pkg::seq_len - 2);
      run_game("timeout game", -1, -1, quiet_round, rand_below(quiet_round + 1));

      bad_round = rand_below(game_pkg::seq_len);
      run_game("second wrong move game", bad_round, rand_below(bad_round + 1), -1, -1);

      run_game("second won game", -1, -1, -1, -1);

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/game_pkg.sv
hw/phase_timer.sv
hw/sequence_memory.sv
hw/round_tracker.sv
hw/player_port.sv
hw/game_control.sv
hw/game_top.sv
sim/game_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module game_tb \
   -f verilog.f \
   -o game_sim

./obj_dir/game_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
   echo "Simulation failed"
   exit 1
fi

echo "Simulation passed"
